//--- logic/isaPkg.sv
// MIPS instruction encoding
`default_nettype none

package isaPkg;

    // Data and address words
    typedef logic [31:0] word;

    // Register number
    typedef logic [4:0] regAddr;

    // Instruction fields
    typedef logic [15:0] imm16;
    typedef logic [25:0] jumpIndex;
    typedef logic [5:0]  opcode;
    typedef logic [5:0]  funct;

    // Primary opcodes of the supported subset
    localparam opcode opSpecial = 6'h00;
    localparam opcode opJ       = 6'h02;
    localparam opcode opBeq     = 6'h04;
    localparam opcode opOri     = 6'h0d;
    localparam opcode opLui     = 6'h0f;
    localparam opcode opLw      = 6'h23;
    localparam opcode opSw      = 6'h2b;

    // Function codes under opSpecial
    localparam funct fnAddu = 6'h21;
    localparam funct fnSubu = 6'h23;

    // ALU operations
    typedef enum logic [1:0] {
        aluAdd,
        aluSub,
        aluOr,
        aluLui
    } aluOp;

endpackage

`default_nettype wire

//--- logic/pipePkg.sv
// Pipeline stage records
`default_nettype none

package pipePkg;

    // Tuse and Tnew counts in cycles
    typedef logic [1:0] timeCount;

    // Forward source for one operand
    typedef enum logic [1:0] {
        fwdNone,
        fwdFromM,
        fwdFromW
    } fwdSel;

    // Control decoded once in D and carried down the pipe
    typedef struct packed {
        logic           aluSrcImm;
        logic           zeroExt;
        isaPkg::aluOp   aluOp;
        logic           memWrite;
        logic           memToReg;
        // Never set together with writeDest 0
        logic           regWrite;
        isaPkg::regAddr writeDest;
        // Cycles until the result exists
        timeCount       tnew;
    } ctrlBits;

    // D/E register
    typedef struct packed {
        isaPkg::word    pc;
        isaPkg::regAddr rs;
        isaPkg::regAddr rt;
        isaPkg::word    rsVal;
        isaPkg::word    rtVal;
        isaPkg::imm16   imm;
        ctrlBits        ctrl;
    } deStage;

    // E/M register
    typedef struct packed {
        isaPkg::word    pc;
        isaPkg::regAddr rt;
        isaPkg::word    aluResult;
        isaPkg::word    storeVal;
        ctrlBits        ctrl;
    } emStage;

    // M/W register, also the register file write port
    typedef struct packed {
        isaPkg::word    pc;
        isaPkg::word    wbData;
        logic           regWrite;
        isaPkg::regAddr writeDest;
    } mwStage;

    // Operand select between own value and the M or W result
    function automatic isaPkg::word fwdMux(input fwdSel sel, input isaPkg::word own,
                                           input isaPkg::word valM, input isaPkg::word valW);
        case (sel)
            fwdFromM: return valM;
            fwdFromW: return valW;
            default:  return own;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- logic/fetchStage.sv
// Instruction fetch stage
`timescale 1ns/1ps
`default_nettype none

module fetchStage #(
    parameter isaPkg::word resetPc = 32'h3000
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        stall,
    input  logic        branchTaken,
    input  isaPkg::word branchTarget,
    input  isaPkg::word imemData,
    output isaPkg::word imemAddr,
    output isaPkg::word pcD,
    output isaPkg::word instrD
);
    import isaPkg::*;

    word pc;
    word nextPc;

    // Instruction memory answers in the same cycle
    assign imemAddr = pc;

    // Taken beq or j in D redirects, otherwise sequential
    assign nextPc = branchTaken ? branchTarget : pc + 32'd4;

    // PC and F/D both hold on a stall
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc     <= resetPc;
            pcD    <= '0;
            // All-zero word decodes to no control
            instrD <= '0;
        end else if (!stall) begin
            pc     <= nextPc;
            pcD    <= pc;
            instrD <= imemData;
        end
    end

endmodule

`default_nettype wire

//--- logic/instrDecoder.sv
// Instruction decoder
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  isaPkg::word       instr,
    output pipePkg::ctrlBits  ctrl,
    output logic              readsRs,
    output logic              readsRt,
    output logic              isBeq,
    output logic              isJump,
    output pipePkg::timeCount tuseRs,
    output pipePkg::timeCount tuseRt
);
    import isaPkg::*;

    opcode op;
    funct  fn;

    assign op = instr[31:26];
    assign fn = instr[5:0];

    always_comb begin
        // Unknown codes fall through with everything cleared
        ctrl    = '0;
        readsRs = 1'b0;
        readsRt = 1'b0;
        isBeq   = 1'b0;
        isJump  = 1'b0;
        tuseRs  = 2'd0;
        tuseRt  = 2'd0;
        case (op)
            opSpecial: begin
                if (fn == fnAddu || fn == fnSubu) begin
                    ctrl.aluOp     = (fn == fnSubu) ? aluSub : aluAdd;
                    ctrl.regWrite  = 1'b1;
                    ctrl.writeDest = instr[15:11];
                    ctrl.tnew      = 2'd1;
                    readsRs        = 1'b1;
                    readsRt        = 1'b1;
                    tuseRs         = 2'd1;
                    tuseRt         = 2'd1;
                end
            end
            opOri, opLui: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.zeroExt   = 1'b1;
                ctrl.aluOp     = (op == opLui) ? aluLui : aluOr;
                ctrl.regWrite  = 1'b1;
                ctrl.writeDest = instr[20:16];
                ctrl.tnew      = 2'd1;
                // lui ignores rs
                readsRs        = (op == opOri);
                tuseRs         = 2'd1;
            end
            opLw: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.writeDest = instr[20:16];
                // Data exists only after the memory stage
                ctrl.tnew      = 2'd2;
                readsRs        = 1'b1;
                tuseRs         = 2'd1;
            end
            opSw: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWrite  = 1'b1;
                readsRs        = 1'b1;
                readsRt        = 1'b1;
                tuseRs         = 2'd1;
                // Store data needed only in M
                tuseRt         = 2'd2;
            end
            opBeq: begin
                // Compared in D, so no slack at all
                isBeq   = 1'b1;
                readsRs = 1'b1;
                readsRt = 1'b1;
            end
            opJ: isJump = 1'b1;
            default: ;
        endcase
        // Writes to register 0 are dropped here once
        if (ctrl.writeDest == '0) begin
            ctrl.regWrite = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/regFile.sv
// General purpose register file
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic           clk,
    input  logic           rstN,
    input  logic           wbEn,
    input  isaPkg::regAddr rs,
    input  isaPkg::regAddr rt,
    input  isaPkg::regAddr wbAddr,
    input  isaPkg::word    wbData,
    output isaPkg::word    rsVal,
    output isaPkg::word    rtVal
);
    import isaPkg::*;

    word regs [32];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && wbAddr != '0) begin
            regs[wbAddr] <= wbData;
        end
    end

    // W-stage write shows up in the same cycle's read
    assign rsVal = (wbEn && wbAddr != '0 && wbAddr == rs) ? wbData : regs[rs];
    assign rtVal = (wbEn && wbAddr != '0 && wbAddr == rt) ? wbData : regs[rt];

endmodule

`default_nettype wire

//--- logic/decodeStage.sv
// Decode stage with branch resolution
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  logic              clk,
    input  logic              rstN,
    input  logic              stall,
    input  isaPkg::word       instrD,
    input  isaPkg::word       pcD,
    input  isaPkg::word       fwdValM,
    input  isaPkg::word       wbData,
    input  pipePkg::fwdSel    fwdDRs,
    input  pipePkg::fwdSel    fwdDRt,
    input  logic              wbEn,
    input  isaPkg::regAddr    wbAddr,
    output isaPkg::regAddr    rs,
    output isaPkg::regAddr    rt,
    output logic              readsRs,
    output logic              readsRt,
    output pipePkg::timeCount tuseRs,
    output pipePkg::timeCount tuseRt,
    output logic              branchTaken,
    output isaPkg::word       branchTarget,
    output pipePkg::deStage   deOut
);
    import isaPkg::*;
    import pipePkg::*;

    ctrlBits  ctrl;
    logic     isBeq;
    logic     isJump;
    word      rsRaw;
    word      rtRaw;
    word      rsVal;
    word      rtVal;
    word      pcPlus4;
    imm16     imm;
    jumpIndex index;

    assign rs    = instrD[25:21];
    assign rt    = instrD[20:16];
    assign imm   = instrD[15:0];
    assign index = instrD[25:0];

    instrDecoder decoder (
        .instr   (instrD),
        .ctrl    (ctrl),
        .readsRs (readsRs),
        .readsRt (readsRt),
        .isBeq   (isBeq),
        .isJump  (isJump),
        .tuseRs  (tuseRs),
        .tuseRt  (tuseRt)
    );

    regFile regs (
        .clk    (clk),
        .rstN   (rstN),
        .wbEn   (wbEn),
        .rs     (rs),
        .rt     (rt),
        .wbAddr (wbAddr),
        .wbData (wbData),
        .rsVal  (rsRaw),
        .rtVal  (rtRaw)
    );

    // Comparator operands, also what D/E captures
    assign rsVal = fwdMux(fwdDRs, rsRaw, fwdValM, wbData);
    assign rtVal = fwdMux(fwdDRt, rtRaw, fwdValM, wbData);

    // Targets are relative to the delay slot
    assign pcPlus4      = pcD + 32'd4;
    assign branchTaken  = isJump || (isBeq && rsVal == rtVal);
    assign branchTarget = isJump ? {pcPlus4[31:28], index, 2'b00}
                                 : pcPlus4 + {{14{imm[15]}}, imm, 2'b00};

    // Stall sends a bubble down while F/D holds
    always_ff @(posedge clk) begin
        if (!rstN || stall) begin
            deOut <= '0;
        end else begin
            deOut.pc    <= pcD;
            deOut.rs    <= rs;
            deOut.rt    <= rt;
            deOut.rsVal <= rsVal;
            deOut.rtVal <= rtVal;
            deOut.imm   <= imm;
            deOut.ctrl  <= ctrl;
        end
    end

endmodule

`default_nettype wire

//--- logic/executeStage.sv
// Execute stage
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  logic             clk,
    input  logic             rstN,
    input  pipePkg::deStage  deIn,
    input  pipePkg::fwdSel   fwdERs,
    input  pipePkg::fwdSel   fwdERt,
    input  isaPkg::word      fwdValM,
    input  isaPkg::word      wbData,
    output pipePkg::emStage  emOut
);
    import isaPkg::*;
    import pipePkg::*;

    word     opA;
    word     opB;
    word     immExt;
    word     aluB;
    word     aluOut;
    ctrlBits ctrlNext;

    // ori and lui take the raw field, the rest sign-extend
    assign immExt = deIn.ctrl.zeroExt ? {16'h0000, deIn.imm}
                                      : {{16{deIn.imm[15]}}, deIn.imm};

    // Newest value wins, M before W
    assign opA  = fwdMux(fwdERs, deIn.rsVal, fwdValM, wbData);
    assign opB  = fwdMux(fwdERt, deIn.rtVal, fwdValM, wbData);
    assign aluB = deIn.ctrl.aluSrcImm ? immExt : opB;

    always_comb begin
        case (deIn.ctrl.aluOp)
            aluAdd:  aluOut = opA + aluB;
            aluSub:  aluOut = opA - aluB;
            aluOr:   aluOut = opA | aluB;
            default: aluOut = {aluB[15:0], 16'h0000};
        endcase
    end

    // One stage closer to the result, floored at zero
    always_comb begin
        ctrlNext = deIn.ctrl;
        if (ctrlNext.tnew != 2'd0) begin
            ctrlNext.tnew = ctrlNext.tnew - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            emOut <= '0;
        end else begin
            emOut.pc        <= deIn.pc;
            emOut.rt        <= deIn.rt;
            emOut.aluResult <= aluOut;
            // Store data may still be stale, M patches it from W
            emOut.storeVal  <= opB;
            emOut.ctrl      <= ctrlNext;
        end
    end

endmodule

`default_nettype wire

//--- logic/memoryStage.sv
// Memory access stage
`timescale 1ns/1ps
`default_nettype none

module memoryStage #(
    parameter int dmemAddrBits = 10
) (
    input  logic            clk,
    input  logic            rstN,
    input  pipePkg::emStage emIn,
    input  pipePkg::fwdSel  fwdMStore,
    input  isaPkg::word     wbData,
    output pipePkg::mwStage mwOut
);
    import isaPkg::*;
    import pipePkg::*;

    localparam int memWords = 1 << dmemAddrBits;

    word                     mem [memWords];
    logic [dmemAddrBits-1:0] wordAddr;
    word                     storeData;
    word                     loadData;

    // Word addressed, byte offset ignored
    assign wordAddr = emIn.aluResult[dmemAddrBits+1:2];

    // Load result retiring in W can still feed a store here
    assign storeData = (fwdMStore == fwdFromW) ? wbData : emIn.storeVal;

    always_ff @(posedge clk) begin
        if (emIn.ctrl.memWrite) begin
            mem[wordAddr] <= storeData;
        end
    end

    // Asynchronous read
    assign loadData = mem[wordAddr];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            mwOut <= '0;
        end else begin
            mwOut.pc        <= emIn.pc;
            mwOut.wbData    <= emIn.ctrl.memToReg ? loadData : emIn.aluResult;
            mwOut.regWrite  <= emIn.ctrl.regWrite;
            mwOut.writeDest <= emIn.ctrl.writeDest;
        end
    end

endmodule

`default_nettype wire

//--- logic/hazardUnit.sv
// Stall and forwarding control
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  isaPkg::regAddr    rs,
    input  isaPkg::regAddr    rt,
    input  isaPkg::regAddr    rsE,
    input  isaPkg::regAddr    rtE,
    input  isaPkg::regAddr    rtM,
    input  logic              readsRs,
    input  logic              readsRt,
    input  pipePkg::timeCount tuseRs,
    input  pipePkg::timeCount tuseRt,
    input  pipePkg::ctrlBits  ctrlE,
    input  pipePkg::ctrlBits  ctrlM,
    input  pipePkg::mwStage   mwIn,
    output logic              stall,
    output pipePkg::fwdSel    fwdDRs,
    output pipePkg::fwdSel    fwdDRt,
    output pipePkg::fwdSel    fwdERs,
    output pipePkg::fwdSel    fwdERt,
    output pipePkg::fwdSel    fwdMStore
);
    import isaPkg::*;
    import pipePkg::*;

    logic stallRs;
    logic stallRt;

    // Producer still owes its result after the consumer needs it
    function automatic logic isLate(input regAddr src, input timeCount tuse,
                                    input ctrlBits prod);
        return prod.regWrite && prod.writeDest == src && prod.tnew > tuse;
    endfunction

    // Nearest matching producer decides
    // A closer one without a value yet blocks older ones
    function automatic fwdSel pickSrc(input regAddr src, input logic closerHit,
                                      input ctrlBits m, input mwStage w);
        if (closerHit) begin
            return fwdNone;
        end
        if (m.regWrite && m.writeDest == src) begin
            if (m.tnew == 2'd0) begin
                return fwdFromM;
            end
            return fwdNone;
        end
        if (w.regWrite && w.writeDest == src) begin
            return fwdFromW;
        end
        return fwdNone;
    endfunction

    assign stallRs = readsRs && (isLate(rs, tuseRs, ctrlE) || isLate(rs, tuseRs, ctrlM));
    assign stallRt = readsRt && (isLate(rt, tuseRt, ctrlE) || isLate(rt, tuseRt, ctrlM));
    assign stall   = stallRs || stallRt;

    // E has no result to forward, but it may shadow M and W
    assign fwdDRs = pickSrc(rs, ctrlE.regWrite && ctrlE.writeDest == rs, ctrlM, mwIn);
    assign fwdDRt = pickSrc(rt, ctrlE.regWrite && ctrlE.writeDest == rt, ctrlM, mwIn);

    assign fwdERs = pickSrc(rsE, 1'b0, ctrlM, mwIn);
    assign fwdERt = pickSrc(rtE, 1'b0, ctrlM, mwIn);

    // Store data in M only looks back at W
    assign fwdMStore = (mwIn.regWrite && mwIn.writeDest == rtM) ? fwdFromW : fwdNone;

endmodule

`default_nettype wire

//--- logic/mipsDatapath.sv
// Five-stage MIPS pipeline top
`timescale 1ns/1ps
`default_nettype none

module mipsDatapath #(
    parameter isaPkg::word resetPc      = 32'h3000,
    parameter int          dmemAddrBits = 10
) (
    input  logic           clk,
    input  logic           rstN,
    input  isaPkg::word    imemData,
    output isaPkg::word    imemAddr,
    output logic           regWrEn,
    output isaPkg::regAddr regWrAddr,
    output isaPkg::word    regWrData,
    output isaPkg::word    regWrPc
);
    import isaPkg::*;
    import pipePkg::*;

    // F to D
    word      pcD;
    word      instrD;
    // D to F and hazard
    logic     branchTaken;
    word      branchTarget;
    regAddr   rs;
    regAddr   rt;
    logic     readsRs;
    logic     readsRt;
    timeCount tuseRs;
    timeCount tuseRt;
    // Hazard outputs
    logic     stall;
    fwdSel    fwdDRs;
    fwdSel    fwdDRt;
    fwdSel    fwdERs;
    fwdSel    fwdERt;
    fwdSel    fwdMStore;
    // Stage registers
    deStage   deReg;
    emStage   emReg;
    mwStage   mwReg;

    fetchStage #(.resetPc(resetPc)) fetch (
        .clk          (clk),
        .rstN         (rstN),
        .stall        (stall),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .imemData     (imemData),
        .imemAddr     (imemAddr),
        .pcD          (pcD),
        .instrD       (instrD)
    );

    decodeStage decode (
        .clk          (clk),
        .rstN         (rstN),
        .stall        (stall),
        .instrD       (instrD),
        .pcD          (pcD),
        .fwdValM      (emReg.aluResult),
        .wbData       (mwReg.wbData),
        .fwdDRs       (fwdDRs),
        .fwdDRt       (fwdDRt),
        .wbEn         (mwReg.regWrite),
        .wbAddr       (mwReg.writeDest),
        .rs           (rs),
        .rt           (rt),
        .readsRs      (readsRs),
        .readsRt      (readsRt),
        .tuseRs       (tuseRs),
        .tuseRt       (tuseRt),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .deOut        (deReg)
    );

    executeStage execute (
        .clk     (clk),
        .rstN    (rstN),
        .deIn    (deReg),
        .fwdERs  (fwdERs),
        .fwdERt  (fwdERt),
        .fwdValM (emReg.aluResult),
        .wbData  (mwReg.wbData),
        .emOut   (emReg)
    );

    memoryStage #(.dmemAddrBits(dmemAddrBits)) memory (
        .clk       (clk),
        .rstN      (rstN),
        .emIn      (emReg),
        .fwdMStore (fwdMStore),
        .wbData    (mwReg.wbData),
        .mwOut     (mwReg)
    );

    hazardUnit hazard (
        .rs        (rs),
        .rt        (rt),
        .rsE       (deReg.rs),
        .rtE       (deReg.rt),
        .rtM       (emReg.rt),
        .readsRs   (readsRs),
        .readsRt   (readsRt),
        .tuseRs    (tuseRs),
        .tuseRt    (tuseRt),
        .ctrlE     (deReg.ctrl),
        .ctrlM     (emReg.ctrl),
        .mwIn      (mwReg),
        .stall     (stall),
        .fwdDRs    (fwdDRs),
        .fwdDRt    (fwdDRt),
        .fwdERs    (fwdERs),
        .fwdERt    (fwdERt),
        .fwdMStore (fwdMStore)
    );

    // Retirement trace is the register file write port
    assign regWrEn   = mwReg.regWrite;
    assign regWrAddr = mwReg.writeDest;
    assign regWrData = mwReg.wbData;
    assign regWrPc   = mwReg.pc;

endmodule

`default_nettype wire

//--- testbench/mipsDatapath_assert.sv
// Pipeline top-level assertions
`timescale 1ns/1ps
`default_nettype none

module mipsDatapathAssert (
    input logic        clk,
    input logic        rstN,
    input logic        regWrEn,
    input logic [4:0]  regWrAddr,
    input logic [31:0] imemAddr,
    input logic        stall
);

    // Stage registers clear on the first reset edge
    quietInReset: assert property (@(posedge clk) !rstN |=> !regWrEn)
        else $error("register write strobe active during reset");

    // Decoder drops writes to register 0
    noWriteToZero: assert property (@(posedge clk) disable iff (!rstN)
        regWrEn |-> regWrAddr != 5'd0)
        else $error("register write reported for register 0");

    alignedFetch: assert property (@(posedge clk) disable iff (!rstN)
        imemAddr[1:0] == 2'b00)
        else $error("fetch address not word aligned");

    // PC holds while the hazard unit stalls
    pcHoldsOnStall: assert property (@(posedge clk) disable iff (!rstN)
        stall |=> $stable(imemAddr))
        else $error("fetch address moved during a stall");

endmodule

bind mipsDatapath mipsDatapathAssert checks (
    .clk       (clk),
    .rstN      (rstN),
    .regWrEn   (regWrEn),
    .regWrAddr (regWrAddr),
    .imemAddr  (imemAddr),
    .stall     (stall)
);

`default_nettype wire

//--- testbench/mipsDatapathTb.sv
// MIPS pipeline testbench
`timescale 1ns/1ps
`default_nettype none

module mipsDatapathTb;

    localparam logic [31:0] resetPc    = 32'h3000;
    localparam int          cycleLimit = 400;

    // Opcode and funct encodings
    localparam logic [5:0] codeSpecial = 6'h00;
    localparam logic [5:0] codeJ       = 6'h02;
    localparam logic [5:0] codeBeq     = 6'h04;
    localparam logic [5:0] codeOri     = 6'h0d;
    localparam logic [5:0] codeLui     = 6'h0f;
    localparam logic [5:0] codeLw      = 6'h23;
    localparam logic [5:0] codeSw      = 6'h2b;
    localparam logic [5:0] fnAddu      = 6'h21;
    localparam logic [5:0] fnSubu      = 6'h23;

    // One expected register write
    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  dest;
        logic [31:0] val;
    } wrRec;

    logic        clk;
    logic        rstN;
    logic [31:0] imemAddr;
    logic [31:0] imemData;
    logic [31:0] imemOff;
    logic        regWrEn;
    logic [4:0]  regWrAddr;
    logic [31:0] regWrData;
    logic [31:0] regWrPc;

    logic [31:0] imem [256];
    logic [7:0]  progLen;
    wrRec        expQ [$];
    wrRec        expWr;
    int          gotCount;
    int          valueErrors;
    int          otherErrors;
    integer      seed;

    mipsDatapath #(.resetPc(resetPc), .dmemAddrBits(10)) UUT (
        .clk       (clk),
        .rstN      (rstN),
        .imemData  (imemData),
        .imemAddr  (imemAddr),
        .regWrEn   (regWrEn),
        .regWrAddr (regWrAddr),
        .regWrData (regWrData),
        .regWrPc   (regWrPc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Same-cycle instruction memory with nop outside the program
    assign imemOff  = imemAddr - resetPc;
    assign imemData = (imemOff < 32'd1024) ? imem[imemOff[9:2]] : 32'd0;

    function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] fn);
        return {codeSpecial, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jumpTo(input logic [31:0] target);
        return {codeJ, target[27:2]};
    endfunction

    function automatic void emit(input logic [31:0] instr);
        imem[progLen] = instr;
        progLen = progLen + 8'd1;
    endfunction

    // Random register in 1 to 7
    function automatic logic [4:0] pickReg(input logic [2:0] v);
        return {2'b00, (v == 3'd0) ? 3'd7 : v};
    endfunction

    // ISA-level run with one delay slot up to the self-jump
    function automatic void runModel();
        logic [31:0] regs [32];
        logic [31:0] dmem [1024];
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] nextNpc;
        logic [31:0] off;
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        logic [31:0] addr;
        logic [4:0]  dest;
        logic        wr;
        logic        done;
        wrRec        rec;
        int          steps;
        expQ.delete();
        for (int i = 0; i < 32; i++) begin
            regs[i] = 32'd0;
        end
        for (int i = 0; i < 1024; i++) begin
            dmem[i] = 32'd0;
        end
        pc    = resetPc;
        npc   = resetPc + 32'd4;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 2000) begin
            off     = pc - resetPc;
            instr   = (off < 32'd1024) ? imem[off[9:2]] : 32'd0;
            a       = regs[instr[25:21]];
            b       = regs[instr[20:16]];
            addr    = a + {{16{instr[15]}}, instr[15:0]};
            nextNpc = npc + 32'd4;
            dest    = instr[20:16];
            wr      = 1'b0;
            val     = 32'd0;
            case (instr[31:26])
                codeSpecial: begin
                    dest = instr[15:11];
                    if (instr[5:0] == fnAddu) begin
                        wr  = 1'b1;
                        val = a + b;
                    end else if (instr[5:0] == fnSubu) begin
                        wr  = 1'b1;
                        val = a - b;
                    end
                end
                codeOri: begin
                    wr  = 1'b1;
                    val = a | {16'h0000, instr[15:0]};
                end
                codeLui: begin
                    wr  = 1'b1;
                    val = {instr[15:0], 16'h0000};
                end
                codeLw: begin
                    wr  = 1'b1;
                    val = dmem[addr[11:2]];
                end
                codeSw: dmem[addr[11:2]] = b;
                codeBeq: begin
                    // Offset counts from the delay slot
                    if (a == b) begin
                        nextNpc = pc + 32'd4 + {{14{instr[15]}}, instr[15:0], 2'b00};
                    end
                end
                codeJ: begin
                    nextNpc = {npc[31:28], instr[25:0], 2'b00};
                    done    = (nextNpc == pc);
                end
                default: ;
            endcase
            if (wr && dest != 5'd0) begin
                regs[dest] = val;
                rec.pc     = pc;
                rec.dest   = dest;
                rec.val    = val;
                expQ.push_back(rec);
            end
            pc    = npc;
            npc   = nextNpc;
            steps = steps + 1;
        end
    endfunction

    // Reset goes low before the old program is wiped
    task automatic startProgram();
        @(negedge clk);
        rstN = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'd0;
        end
        progLen = 8'd0;
    endtask

    task automatic runProgram(input string name);
        int cycles;
        // Closing self-jump and its delay slot
        emit(jumpTo(resetPc + {22'd0, progLen, 2'b00}));
        emit(32'd0);
        runModel();
        gotCount = 0;
        repeat (10) @(negedge clk);
        rstN = 1'b1;
        assert (imemAddr == resetPc) else begin
            valueErrors++;
            $display("** Error: imemAddr = %h, expected %h", imemAddr, resetPc);
        end
        cycles = 0;
        while (gotCount < expQ.size() && cycles < cycleLimit) begin
            @(negedge clk);
            cycles++;
        end
        if (gotCount < expQ.size()) begin
            otherErrors++;
            $display("Timeout in %s program: %0d of %0d writes seen after %0d cycles",
                     name, gotCount, expQ.size(), cycles);
        end
        // Extra cycles so stray writes still show up
        repeat (6) @(negedge clk);
    endtask

    task automatic buildRandomProgram();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] offset;
        // Clear the data words in use since data memory is not reset
        for (int k = 0; k < 8; k++) begin
            emit(iType(codeSw, 5'd0, 5'd0, 16'(k * 4)));
        end
        for (int n = 0; n < 40; n++) begin
            r      = $random(seed);
            rd     = pickReg(r[2:0]);
            rs     = pickReg(r[5:3]);
            rt     = pickReg(r[8:6]);
            offset = {11'd0, r[11:9], 2'b00};
            case (r[14:12])
                3'd0, 3'd1: emit(rType(rs, rt, rd, fnAddu));
                3'd2:       emit(rType(rs, rt, rd, fnSubu));
                3'd3:       emit(iType(codeOri, rs, rd, r[31:16]));
                3'd4:       emit(iType(codeLui, 5'd0, rd, r[31:16]));
                3'd5, 3'd6: emit(iType(codeLw, 5'd0, rd, offset));
                default:    emit(iType(codeSw, 5'd0, rt, offset));
            endcase
        end
    endtask

    // Every retirement against the next expected write
    always @(posedge clk) begin
        if (rstN && regWrEn) begin
            assert (gotCount < expQ.size()) else begin
                otherErrors++;
                $display("Register write not expected by the model at pc %h", regWrPc);
            end
            if (gotCount < expQ.size()) begin
                expWr = expQ[gotCount];
                assert (regWrPc == expWr.pc) else begin
                    valueErrors++;
                    $display("** Error: regWrPc = %h, expected %h", regWrPc, expWr.pc);
                end
                assert (regWrAddr == expWr.dest) else begin
                    valueErrors++;
                    $display("** Error: regWrAddr = %h, expected %h", regWrAddr, expWr.dest);
                end
                assert (regWrData == expWr.val) else begin
                    valueErrors++;
                    $display("** Error: regWrData = %h, expected %h", regWrData, expWr.val);
                end
            end
            gotCount++;
        end
    end

    initial begin
        seed        = 32'h49437601;
        rstN        = 1'b0;
        progLen     = 8'd0;
        gotCount    = 0;
        valueErrors = 0;
        otherErrors = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'd0;
        end

        // Independent ALU operations
        startProgram();
        emit(iType(codeOri, 5'd0, 5'd1, 16'h1234));
        emit(iType(codeOri, 5'd0, 5'd2, 16'h00f0));
        emit(iType(codeLui, 5'd0, 5'd3, 16'habcd));
        emit(iType(codeOri, 5'd0, 5'd4, 16'h8001));
        emit(iType(codeLui, 5'd0, 5'd5, 16'h7fff));
        emit(32'd0);
        emit(32'd0);
        emit(rType(5'd1, 5'd2, 5'd6, fnAddu));
        emit(rType(5'd4, 5'd1, 5'd7, fnSubu));
        runProgram("independent");

        // Back-to-back chains through M and W
        startProgram();
        emit(iType(codeOri, 5'd0, 5'd1, 16'h0005));
        emit(rType(5'd1, 5'd1, 5'd2, fnAddu));
        emit(rType(5'd2, 5'd1, 5'd3, fnSubu));
        emit(rType(5'd3, 5'd2, 5'd4, fnAddu));
        emit(iType(codeOri, 5'd4, 5'd5, 16'h0100));
        emit(iType(codeLui, 5'd0, 5'd6, 16'h8000));
        emit(rType(5'd6, 5'd5, 5'd7, fnAddu));
        emit(rType(5'd7, 5'd3, 5'd1, fnSubu));
        runProgram("forwarding");

        // Stores with forwarded data and a load-use pair
        startProgram();
        emit(iType(codeOri, 5'd0, 5'd1, 16'h0040));
        emit(iType(codeOri, 5'd0, 5'd2, 16'h7777));
        emit(iType(codeSw, 5'd1, 5'd2, 16'h0000));
        emit(iType(codeLw, 5'd1, 5'd3, 16'h0000));
        emit(rType(5'd3, 5'd3, 5'd4, fnAddu));
        emit(iType(codeLui, 5'd0, 5'd5, 16'h1234));
        emit(iType(codeSw, 5'd1, 5'd5, 16'h0004));
        emit(iType(codeLw, 5'd1, 5'd6, 16'h0004));
        emit(iType(codeSw, 5'd1, 5'd6, 16'h0008));
        emit(iType(codeLw, 5'd1, 5'd7, 16'h0008));
        emit(rType(5'd7, 5'd2, 5'd1, fnSubu));
        runProgram("memory");

        // Taken and untaken beq and a j to index 11
        startProgram();
        emit(iType(codeOri, 5'd0, 5'd1, 16'h0003));
        emit(iType(codeOri, 5'd0, 5'd2, 16'h0003));
        emit(iType(codeBeq, 5'd1, 5'd2, 16'd2));
        emit(iType(codeOri, 5'd0, 5'd3, 16'h0011));
        emit(iType(codeOri, 5'd0, 5'd4, 16'h0022));
        emit(rType(5'd1, 5'd2, 5'd5, fnAddu));
        emit(iType(codeBeq, 5'd5, 5'd1, 16'd3));
        emit(iType(codeOri, 5'd0, 5'd6, 16'h0033));
        emit(jumpTo(resetPc + 32'd44));
        emit(iType(codeOri, 5'd0, 5'd7, 16'h0044));
        emit(iType(codeOri, 5'd0, 5'd4, 16'h0055));
        emit(rType(5'd5, 5'd1, 5'd4, fnSubu));
        runProgram("branch");

        startProgram();
        buildRandomProgram();
        runProgram("random");

        $display("Checks done: %0d value errors, %0d other errors", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
logic/isaPkg.sv
logic/pipePkg.sv
logic/fetchStage.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/hazardUnit.sv
logic/mipsDatapath.sv
testbench/mipsDatapath_assert.sv
testbench/mipsDatapathTb.sv

//--- run.sh
#!/bin/bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module mipsDatapathTb -f sim.f --Mdir obj_dir -o mipsSim
./obj_dir/mipsSim 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation passed"
